/* hdl/acq_readout_pkg.sv */
`include "acq_readout_settings.svh"

package acq_readout_pkg;

    // two adc samples in the low 24 bits, zero padding above
    typedef struct packed {
        logic [`WORD_W-2*`SAMPLE_W-1:0] pad;
        logic [`SAMPLE_W-1:0]           sample_b;
        logic [`SAMPLE_W-1:0]           sample_a;
    } sample_pair_t;

    typedef enum logic [2:0] {
        REC_NONE     = 3'd0,
        REC_WFM_HDR  = 3'd1,
        REC_DATA     = 3'd2,
        REC_CHECKSUM = 3'd3,
        REC_FILL_HDR = 3'd4
    } record_kind_e;

    // per-cycle command from the fill sequencer
    typedef struct packed {
        logic                    read_init;
        logic                    read_inc;
        logic                    latch_word;
        logic                    last_word;
        record_kind_e            record_kind;
        logic                    emit;
        logic                    fill_start;
        logic [`BURST_CNT_W-1:0] bursts;
        logic [`CBUF_ADDR_W-1:0] trig_addr;
    } seq_cmd_t;

    // command after the buffer read, with the word read for it
    typedef struct packed {
        logic                    latch_word;
        logic                    last_word;
        record_kind_e            record_kind;
        logic                    emit;
        logic                    fill_start;
        logic [`BURST_CNT_W-1:0] bursts;
        logic [`CBUF_ADDR_W-1:0] trig_addr;
        logic [`WORD_W-1:0]      word;
    } stage_cmd_t;

    // record candidate, payload widened to a full burst
    typedef struct packed {
        record_kind_e            record_kind;
        logic                    emit;
        logic                    fill_start;
        logic [`BURST_CNT_W-1:0] bursts;
        logic [`CBUF_ADDR_W-1:0] trig_addr;
        logic [`BURST_W-1:0]     payload;
    } burst_cmd_t;

    typedef struct packed {
        logic [`BURST_W-1:0] payload;
        record_kind_e        record_kind;
    } record_t;

endpackage

/* hdl/acq_readout_settings.svh */
`ifndef ACQ_READOUT_SETTINGS_SVH
`define ACQ_READOUT_SETTINGS_SVH

// circular sample buffer of 1024 words
`define CBUF_ADDR_W 10
// adc sample, two of them packed per buffer word
`define SAMPLE_W 12
`define WORD_W 32
// a burst is four consecutive buffer words
`define WORDS_PER_BURST 4
`define BURST_W 128
`define BURST_CNT_W 8
`define TRIG_FIFO_DEPTH 4
`define CHECKSUM_W 32
// counters carried in the headers
`define WFM_CNT_W 16
`define REC_CNT_W 32
// record tags sit in bits 127:112
`define TAG_W 16
`define WFM_HDR_TAG 16'hA5E1
`define CHECKSUM_TAG 16'hC5C5
`define FILL_HDR_TAG 16'hF111

`endif

/* hdl/acq_readout_top.sv */
`include "acq_readout_settings.svh"

module acq_readout_top (
    input  logic                          adc_clk,
    input  logic                          reset_clk_adc,
    input  logic                          adc_wr_en,
    input  acq_readout_pkg::sample_pair_t adc_sample,
    input  logic                          rd_en,
    input  logic                          trig_en,
    input  logic [`BURST_CNT_W-1:0]       bursts_per_wfm,
    input  logic                          trig_req,
    input  logic [`CBUF_ADDR_W-1:0]       trig_addr,
    output logic                          trig_ack,
    output logic                          trig_wait,
    output logic                          wr_active,
    output acq_readout_pkg::record_t      record,
    output logic                          record_valid
);

    logic                        fifo_empty;
    logic                        trig_rd_en;
    logic [`CBUF_ADDR_W-1:0]     head_addr;
    acq_readout_pkg::seq_cmd_t   cmd;
    acq_readout_pkg::stage_cmd_t stage;
    acq_readout_pkg::burst_cmd_t packed_cmd;

    // trigger entry
    trig_fifo u_trig_fifo (
        .adc_clk       (adc_clk),
        .reset_clk_adc (reset_clk_adc),
        .trig_req      (trig_req),
        .trig_addr     (trig_addr),
        .trig_rd_en    (trig_rd_en),
        .trig_ack      (trig_ack),
        .fifo_empty    (fifo_empty),
        .head_addr     (head_addr)
    );

    fill_sequencer u_fill_sequencer (
        .adc_clk        (adc_clk),
        .reset_clk_adc  (reset_clk_adc),
        .rd_en          (rd_en),
        .trig_en        (trig_en),
        .fifo_empty     (fifo_empty),
        .head_addr      (head_addr),
        .bursts_per_wfm (bursts_per_wfm),
        .trig_rd_en     (trig_rd_en),
        .trig_wait      (trig_wait),
        .wr_active      (wr_active),
        .cmd            (cmd)
    );

    // three register stages from command to record
    circ_buf_reader u_circ_buf_reader (
        .adc_clk    (adc_clk),
        .adc_wr_en  (adc_wr_en),
        .adc_sample (adc_sample),
        .cmd        (cmd),
        .stage      (stage)
    );

    burst_assembler u_burst_assembler (
        .adc_clk       (adc_clk),
        .reset_clk_adc (reset_clk_adc),
        .stage         (stage),
        .packed_cmd    (packed_cmd)
    );

    record_formatter u_record_formatter (
        .adc_clk       (adc_clk),
        .reset_clk_adc (reset_clk_adc),
        .packed_cmd    (packed_cmd),
        .record        (record),
        .record_valid  (record_valid)
    );

endmodule

/* hdl/burst_assembler.sv */
`include "acq_readout_settings.svh"

module burst_assembler (
    input  logic                        adc_clk,
    input  logic                        reset_clk_adc,
    input  acq_readout_pkg::stage_cmd_t stage,
    output acq_readout_pkg::burst_cmd_t packed_cmd
);

    logic [`BURST_W-1:0] lanes;
    logic [`BURST_W-1:0] shifted;

    // new word enters the top lane
    // after four shifts the first word sits in lane 0
    assign shifted = {stage.word, lanes[`BURST_W-1:`WORD_W]};

    always_ff @(posedge adc_clk) begin
        if (stage.latch_word) begin
            lanes <= shifted;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            packed_cmd <= '0;
        end else begin
            // headers and fill commands pass one stage along
            packed_cmd.record_kind <= stage.record_kind;
            packed_cmd.emit        <= stage.emit;
            packed_cmd.fill_start  <= stage.fill_start;
            packed_cmd.bursts      <= stage.bursts;
            packed_cmd.trig_addr   <= stage.trig_addr;
            // fourth word completes the burst, taken straight from the shifter
            if (stage.last_word) begin
                packed_cmd.payload <= shifted;
            end
        end
    end

endmodule

/* hdl/circ_buf_reader.sv */
`include "acq_readout_settings.svh"

module circ_buf_reader (
    input  logic                          adc_clk,
    input  logic                          adc_wr_en,
    input  acq_readout_pkg::sample_pair_t adc_sample,
    input  acq_readout_pkg::seq_cmd_t     cmd,
    output acq_readout_pkg::stage_cmd_t   stage
);

    logic [`WORD_W-1:0]      mem [1 << `CBUF_ADDR_W];
    // power-up value, the write side free runs after that
    logic [`CBUF_ADDR_W-1:0] wr_ptr = '0;
    logic [`CBUF_ADDR_W-1:0] rd_ptr;

    // adc side, one sample pair per enabled cycle
    always_ff @(posedge adc_clk) begin
        if (adc_wr_en) begin
            mem[wr_ptr] <= adc_sample;
            wr_ptr      <= wr_ptr + 1'b1;
        end
    end

    // read pointer wraps at the buffer end by width
    always_ff @(posedge adc_clk) begin
        if (cmd.read_init) begin
            rd_ptr <= cmd.trig_addr;
        end else if (cmd.read_inc) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // registered read, command travels with its word
    always_ff @(posedge adc_clk) begin
        stage.word        <= mem[rd_ptr];
        stage.latch_word  <= cmd.latch_word;
        stage.last_word   <= cmd.last_word;
        stage.record_kind <= cmd.record_kind;
        stage.emit        <= cmd.emit;
        stage.fill_start  <= cmd.fill_start;
        stage.bursts      <= cmd.bursts;
        stage.trig_addr   <= cmd.trig_addr;
    end

endmodule

/* hdl/fill_sequencer.sv */
`include "acq_readout_settings.svh"

module fill_sequencer (
    input  logic                      adc_clk,
    input  logic                      reset_clk_adc,
    input  logic                      rd_en,
    input  logic                      trig_en,
    input  logic                      fifo_empty,
    input  logic [`CBUF_ADDR_W-1:0]   head_addr,
    input  logic [`BURST_CNT_W-1:0]   bursts_per_wfm,
    output logic                      trig_rd_en,
    output logic                      trig_wait,
    output logic                      wr_active,
    output acq_readout_pkg::seq_cmd_t cmd
);

    // one-hot state bit positions
    localparam int S_IDLE       = 0;
    localparam int S_FILL_INIT  = 1;
    localparam int S_TRIG_WAIT  = 2;
    localparam int S_WFM_INIT1  = 3;
    localparam int S_WFM_INIT2  = 4;
    localparam int S_LOOP1      = 5;
    localparam int S_LOOP2      = 6;
    localparam int S_LOOP3      = 7;
    localparam int S_LOOP4      = 8;
    localparam int S_WFM_DONE   = 9;
    localparam int S_NO_TRIG    = 10;
    localparam int S_FILL_DONE1 = 11;
    localparam int S_FILL_DONE2 = 12;
    localparam int S_FILL_DONE3 = 13;
    localparam int S_WRITE_WAIT = 14;
    localparam int NUM_STATES   = 15;

    logic [NUM_STATES-1:0]         cs;
    logic [NUM_STATES-1:0]         ns;
    logic                          got_trig;
    logic [`BURST_CNT_W-1:0]       bursts_q;
    logic [`BURST_CNT_W-1:0]       burst_cnt;
    logic                          loop_next;
    acq_readout_pkg::record_kind_e kind_next;

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            cs         <= '0;
            cs[S_IDLE] <= 1'b1;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = '0;
        case (1'b1)
            cs[S_IDLE]:      ns[rd_en ? S_FILL_INIT : S_IDLE] = 1'b1;
            cs[S_FILL_INIT]: ns[S_TRIG_WAIT] = 1'b1;
            cs[S_TRIG_WAIT]: begin
                // a stored trigger always wins, none is dropped at fill end
                if (!fifo_empty) begin
                    ns[S_WFM_INIT1] = 1'b1;
                end else if (!trig_en) begin
                    ns[got_trig ? S_FILL_DONE1 : S_NO_TRIG] = 1'b1;
                end else begin
                    ns[S_TRIG_WAIT] = 1'b1;
                end
            end
            cs[S_WFM_INIT1]: ns[S_WFM_INIT2] = 1'b1;
            // zero bursts means a header-only waveform
            cs[S_WFM_INIT2]: ns[(burst_cnt == '0) ? S_WFM_DONE : S_LOOP1] = 1'b1;
            cs[S_LOOP1]:     ns[S_LOOP2] = 1'b1;
            cs[S_LOOP2]:     ns[S_LOOP3] = 1'b1;
            cs[S_LOOP3]:     ns[S_LOOP4] = 1'b1;
            cs[S_LOOP4]:     ns[(burst_cnt == '0) ? S_WFM_DONE : S_LOOP1] = 1'b1;
            cs[S_WFM_DONE]:  ns[S_TRIG_WAIT] = 1'b1;
            cs[S_NO_TRIG]:   ns[S_FILL_DONE1] = 1'b1;
            // fold fill header, emit checksum, emit fill header
            cs[S_FILL_DONE1]: ns[S_FILL_DONE2] = 1'b1;
            cs[S_FILL_DONE2]: ns[S_FILL_DONE3] = 1'b1;
            cs[S_FILL_DONE3]: ns[S_WRITE_WAIT] = 1'b1;
            // hold until the fill is released by rd_en
            cs[S_WRITE_WAIT]: ns[rd_en ? S_WRITE_WAIT : S_IDLE] = 1'b1;
            default:          ns[S_IDLE] = 1'b1;
        endcase
    end

    assign loop_next = ns[S_LOOP1] | ns[S_LOOP2] | ns[S_LOOP3] | ns[S_LOOP4];

    always_comb begin
        kind_next = acq_readout_pkg::REC_NONE;
        if (ns[S_WFM_INIT2]) begin
            kind_next = acq_readout_pkg::REC_WFM_HDR;
        end else if (ns[S_LOOP4]) begin
            kind_next = acq_readout_pkg::REC_DATA;
        end else if (ns[S_FILL_DONE2]) begin
            kind_next = acq_readout_pkg::REC_CHECKSUM;
        end else if (ns[S_FILL_DONE1] || ns[S_FILL_DONE3]) begin
            kind_next = acq_readout_pkg::REC_FILL_HDR;
        end
    end

    // bursts setting fixed for the whole fill
    always_ff @(posedge adc_clk) begin
        if (ns[S_FILL_INIT]) begin
            bursts_q <= bursts_per_wfm;
        end
    end

    // all outputs registered from the next state
    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            got_trig   <= 1'b0;
            burst_cnt  <= '0;
            trig_rd_en <= 1'b0;
            trig_wait  <= 1'b0;
            wr_active  <= 1'b0;
            cmd        <= '0;
        end else begin
            if (ns[S_FILL_INIT]) begin
                got_trig <= 1'b0;
            end else if (ns[S_WFM_INIT1]) begin
                got_trig <= 1'b1;
            end
            // down-counter, one step per burst
            if (ns[S_WFM_INIT1]) begin
                burst_cnt <= bursts_q;
            end else if (ns[S_LOOP1]) begin
                burst_cnt <= burst_cnt - 1'b1;
            end
            trig_rd_en <= ns[S_WFM_INIT1];
            trig_wait  <= ns[S_TRIG_WAIT];
            wr_active  <= ~(ns[S_IDLE] | ns[S_FILL_INIT] | ns[S_TRIG_WAIT]);

            cmd.read_init   <= ns[S_WFM_INIT1];
            cmd.read_inc    <= loop_next;
            cmd.latch_word  <= loop_next;
            cmd.last_word   <= ns[S_LOOP4];
            cmd.record_kind <= kind_next;
            cmd.emit        <= ns[S_WFM_INIT2] | ns[S_LOOP4] | ns[S_FILL_DONE2] |
                               ns[S_FILL_DONE3];
            cmd.fill_start  <= ns[S_FILL_INIT];
            cmd.bursts      <= bursts_q;
            // head of the FWFT fifo, popped in the same state
            if (ns[S_WFM_INIT1]) begin
                cmd.trig_addr <= head_addr;
            end
        end
    end

endmodule

/* hdl/record_formatter.sv */
`include "acq_readout_settings.svh"

module record_formatter (
    input  logic                        adc_clk,
    input  logic                        reset_clk_adc,
    input  acq_readout_pkg::burst_cmd_t packed_cmd,
    output acq_readout_pkg::record_t    record,
    output logic                        record_valid
);

    logic [`WFM_CNT_W-1:0]  wfm_cnt;
    logic [`REC_CNT_W-1:0]  rec_cnt;
    logic [`CHECKSUM_W-1:0] checksum;
    logic [`BURST_W-1:0]    fill_hdr_q;
    logic [`BURST_W-1:0]    wfm_hdr;
    logic [`BURST_W-1:0]    fill_hdr_now;
    logic [`BURST_W-1:0]    payload;
    logic [`CHECKSUM_W-1:0] lane_sum;
    logic                   is_fold;
    logic                   sum_en;

    always_comb begin
        // numbering starts at 1
        wfm_hdr = '0;
        wfm_hdr[`BURST_W-1 -: `TAG_W]   = `WFM_HDR_TAG;
        wfm_hdr[111:96]                 = wfm_cnt + 1'b1;
        wfm_hdr[47:40]                  = packed_cmd.bursts;
        wfm_hdr[`CBUF_ADDR_W-1:0]       = packed_cmd.trig_addr;
        // the checksum record is still to come, count it now
        fill_hdr_now = '0;
        fill_hdr_now[`BURST_W-1 -: `TAG_W] = `FILL_HDR_TAG;
        fill_hdr_now[111:96]               = wfm_cnt;
        fill_hdr_now[31:0]                 = rec_cnt + 1'b1;
    end

    assign is_fold = (packed_cmd.record_kind == acq_readout_pkg::REC_FILL_HDR) &&
                     !packed_cmd.emit;

    always_comb begin
        case (packed_cmd.record_kind)
            acq_readout_pkg::REC_WFM_HDR:  payload = wfm_hdr;
            acq_readout_pkg::REC_DATA:     payload = packed_cmd.payload;
            acq_readout_pkg::REC_CHECKSUM: payload = {`CHECKSUM_TAG,
                {(`BURST_W-`TAG_W-`CHECKSUM_W){1'b0}}, checksum};
            // emitted fill header is the one folded into the checksum
            acq_readout_pkg::REC_FILL_HDR: payload = is_fold ? fill_hdr_now : fill_hdr_q;
            default:                       payload = '0;
        endcase
    end

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `WORDS_PER_BURST; i++) begin
            lane_sum = lane_sum + payload[i*`WORD_W +: `WORD_W];
        end
    end

    // headers, bursts and the folded fill header enter the sum
    assign sum_en = is_fold || (packed_cmd.emit &&
                    (packed_cmd.record_kind == acq_readout_pkg::REC_WFM_HDR ||
                     packed_cmd.record_kind == acq_readout_pkg::REC_DATA));

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            wfm_cnt      <= '0;
            rec_cnt      <= '0;
            checksum     <= '0;
            record_valid <= 1'b0;
        end else begin
            record_valid <= packed_cmd.emit;
            if (packed_cmd.fill_start) begin
                wfm_cnt  <= '0;
                rec_cnt  <= '0;
                checksum <= '0;
            end else begin
                if (packed_cmd.emit) begin
                    rec_cnt <= rec_cnt + 1'b1;
                end
                if (packed_cmd.emit && packed_cmd.record_kind == acq_readout_pkg::REC_WFM_HDR) begin
                    wfm_cnt <= wfm_cnt + 1'b1;
                end
                if (sum_en) begin
                    checksum <= checksum + lane_sum;
                end
            end
        end
    end

    always_ff @(posedge adc_clk) begin
        if (is_fold) begin
            fill_hdr_q <= fill_hdr_now;
        end
        record.payload     <= payload;
        record.record_kind <= packed_cmd.record_kind;
    end

endmodule

/* hdl/trig_fifo.sv */
`include "acq_readout_settings.svh"

module trig_fifo (
    input  logic                    adc_clk,
    input  logic                    reset_clk_adc,
    input  logic                    trig_req,
    input  logic [`CBUF_ADDR_W-1:0] trig_addr,
    input  logic                    trig_rd_en,
    output logic                    trig_ack,
    output logic                    fifo_empty,
    output logic [`CBUF_ADDR_W-1:0] head_addr
);

    localparam int PTR_W = $clog2(`TRIG_FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = `TRIG_FIFO_DEPTH;

    logic [`CBUF_ADDR_W-1:0] mem [`TRIG_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [PTR_W:0]          count;
    logic                    push;
    logic                    pop;

    // accept only a fresh request, and only when there is room
    assign push       = trig_req & ~trig_ack & (count != FULL_CNT);
    assign pop        = trig_rd_en & ~fifo_empty;
    assign fifo_empty = (count == '0);
    // first word fall through
    assign head_addr  = mem[rd_ptr];

    always_ff @(posedge adc_clk) begin
        if (push) begin
            mem[wr_ptr] <= trig_addr;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            trig_ack <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            // ack follows the store, drops once req is gone
            if (push) begin
                trig_ack <= 1'b1;
            end else if (!trig_req) begin
                trig_ack <= 1'b0;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_acq_readout -f src.f -Mdir obj_dir -o sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim)
echo "$out"
echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1

/* src.f */
+incdir+hdl
hdl/acq_readout_pkg.sv
hdl/trig_fifo.sv
hdl/fill_sequencer.sv
hdl/circ_buf_reader.sv
hdl/burst_assembler.sv
hdl/record_formatter.sv
hdl/acq_readout_top.sv
verif/acq_readout_checker.sv
verif/tb_acq_readout.sv

/* verif/acq_readout_checker.sv */
`include "acq_readout_settings.svh"

module acq_readout_checker (
    input  logic                          adc_clk,
    input  logic                          reset_clk_adc,
    input  logic                          adc_wr_en,
    input  acq_readout_pkg::sample_pair_t adc_sample,
    input  logic                          rd_en,
    input  logic [`BURST_CNT_W-1:0]       bursts_per_wfm,
    input  logic                          trig_req,
    input  logic [`CBUF_ADDR_W-1:0]       trig_addr,
    input  logic                          trig_ack,
    input  logic                          trig_wait,
    input  logic                          wr_active,
    input  acq_readout_pkg::record_t      record,
    input  logic                          record_valid,
    input  int                            test_id,
    input  int                            test_wfms,
    input  logic                          test_done,
    input  logic                          all_done,
    output int                            error_count
);

    typedef logic [`CBUF_ADDR_W-1:0] addr_t;

    // mirror of the sample buffer with the same free running write pointer
    logic [`WORD_W-1:0]      mirror [1 << `CBUF_ADDR_W];
    addr_t                   wr_ptr = '0;
    addr_t                   trig_q [$];
    addr_t                   pend_addr;
    addr_t                   cur_addr;
    logic [`BURST_CNT_W-1:0] fill_bursts;
    logic [`BURST_W-1:0]     fill_hdr_exp;
    logic [`CHECKSUM_W-1:0]  sum;
    logic                    rd_q = 1'b0;
    logic                    req_q = 1'b0;
    logic                    ack_q = 1'b0;
    logic                    wait_q = 1'b0;
    int                      occ = 0;
    int                      wfm_num = 0;
    int                      rec_num = 0;
    int                      bursts_left = 0;
    int                      burst_idx = 0;
    // end step 0 in the body, 1 after the checksum and 2 after the fill header
    int                      end_step = 0;
    int                      errors = 0;
    int                      errors_at_start = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;

    assign error_count = errors;

    function automatic logic [`CHECKSUM_W-1:0] lanes_sum(input logic [`BURST_W-1:0] p);
        lanes_sum = p[31:0] + p[63:32] + p[95:64] + p[127:96];
    endfunction

    // next record of the fill from the model state
    task automatic next_expected(output logic [`BURST_W-1:0] p,
                                 output acq_readout_pkg::record_kind_e k);
        addr_t a;
        p = '0;
        k = acq_readout_pkg::REC_NONE;
        if (bursts_left > 0) begin
            k = acq_readout_pkg::REC_DATA;
            // word 0 goes in the low lane and the address wraps at 1024
            for (int i = 0; i < `WORDS_PER_BURST; i++) begin
                a = cur_addr + addr_t'(`WORDS_PER_BURST * burst_idx + i);
                p[i*`WORD_W +: `WORD_W] = mirror[a];
            end
            burst_idx++;
            bursts_left--;
        end else if (trig_q.size() > 0) begin
            k = acq_readout_pkg::REC_WFM_HDR;
            cur_addr = trig_q.pop_front();
            wfm_num++;
            p[127:112]           = `WFM_HDR_TAG;
            p[111:96]            = 16'(wfm_num);
            p[47:40]             = fill_bursts;
            p[`CBUF_ADDR_W-1:0]  = cur_addr;
            bursts_left          = int'(fill_bursts);
            burst_idx            = 0;
        end else if (end_step == 0) begin
            // record count includes the checksum record itself
            fill_hdr_exp            = '0;
            fill_hdr_exp[127:112]   = `FILL_HDR_TAG;
            fill_hdr_exp[111:96]    = 16'(wfm_num);
            fill_hdr_exp[31:0]      = rec_num + 1;
            sum                     = sum + lanes_sum(fill_hdr_exp);
            k                       = acq_readout_pkg::REC_CHECKSUM;
            p[127:112]              = `CHECKSUM_TAG;
            p[31:0]                 = sum;
            end_step                = 1;
        end else if (end_step == 1) begin
            k        = acq_readout_pkg::REC_FILL_HDR;
            p        = fill_hdr_exp;
            end_step = 2;
        end
        if (k == acq_readout_pkg::REC_WFM_HDR || k == acq_readout_pkg::REC_DATA) begin
            sum = sum + lanes_sum(p);
        end
        if (k != acq_readout_pkg::REC_NONE) begin
            rec_num++;
        end
    endtask

    always @(posedge adc_clk) begin : watch
        logic [`BURST_W-1:0]           exp_p;
        acq_readout_pkg::record_kind_e exp_k;
        if (adc_wr_en) begin
            mirror[wr_ptr] = adc_sample;
            wr_ptr         = wr_ptr + addr_t'(1);
        end
        // a new fill clears the model and takes the bursts setting
        if (rd_en && !rd_q && !reset_clk_adc) begin
            wfm_num     = 0;
            rec_num     = 0;
            sum         = '0;
            end_step    = 0;
            bursts_left = 0;
            fill_bursts = bursts_per_wfm;
        end
        if (trig_req && !req_q) begin
            pend_addr = trig_addr;
        end
        // rising ack means the address was stored
        if (trig_ack && !ack_q) begin
            if (occ >= `TRIG_FIFO_DEPTH) begin
                $display("trigger acknowledged while the FIFO was full");
                errors++;
            end
            trig_q.push_back(pend_addr);
            occ++;
        end
        // leaving trig-wait with entries stored is a pop
        if (wait_q && !trig_wait && occ > 0) begin
            occ--;
        end
        if (record_valid) begin
            next_expected(exp_p, exp_k);
            if (exp_k == acq_readout_pkg::REC_NONE) begin
                $display("record_valid seen after the fill header, no record was expected");
                errors++;
            end else begin
                if (record.record_kind !== exp_k) begin
                    $display("mismatch record.record_kind: got %h expected %h",
                             record.record_kind, exp_k);
                    errors++;
                end
                if (record.payload !== exp_p) begin
                    $display("mismatch record.payload: got %h expected %h",
                             record.payload, exp_p);
                    errors++;
                end
            end
        end
        if (test_done) begin
            if (record_valid || trig_ack || wr_active || trig_wait) begin
                $display("outputs not idle after test %0d", test_id);
                errors++;
            end
            if (test_wfms >= 0) begin
                if (end_step != 2) begin
                    $display("fill did not end with a checksum and a fill header");
                    errors++;
                end
                if (trig_q.size() != 0) begin
                    $display("%0d accepted triggers never became waveforms", trig_q.size());
                    errors++;
                end
                if (wfm_num != test_wfms) begin
                    $display("waveform count wrong, %0d sent and %0d seen", test_wfms, wfm_num);
                    errors++;
                end
            end
            tests_run++;
            if (errors == errors_at_start) begin
                $display("test %0d passed", test_id);
            end else begin
                $display("test %0d failed with %0d errors", test_id, errors - errors_at_start);
                tests_failed++;
            end
            errors_at_start = errors;
        end
        if (all_done) begin
            $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        end
        rd_q   = rd_en;
        req_q  = trig_req;
        ack_q  = trig_ack;
        wait_q = trig_wait;
    end

endmodule

/* verif/tb_acq_readout.sv */
`include "acq_readout_settings.svh"

module tb_acq_readout;

    // run bound from the trigger and burst counts of all tests times a margin
    localparam int N_TRIGS     = 1 + 4 + 6;
    localparam int MAX_BURSTS  = 8;
    localparam int WFM_CYCLES  = 4 * MAX_BURSTS + 16;
    localparam int FILL_CYCLES = 60;
    localparam int LIMIT       = 4 * ((1 << `CBUF_ADDR_W) + N_TRIGS * WFM_CYCLES +
                                      5 * FILL_CYCLES);

    logic                          adc_clk = 1'b0;
    logic                          reset_clk_adc;
    logic                          adc_wr_en;
    acq_readout_pkg::sample_pair_t adc_sample;
    logic                          rd_en;
    logic                          trig_en;
    logic [`BURST_CNT_W-1:0]       bursts_per_wfm;
    logic                          trig_req;
    logic [`CBUF_ADDR_W-1:0]       trig_addr;
    logic                          trig_ack;
    logic                          trig_wait;
    logic                          wr_active;
    acq_readout_pkg::record_t      record;
    logic                          record_valid;
    int                            test_id;
    int                            test_wfms;
    logic                          test_done;
    logic                          all_done;
    int                            error_count;
    integer                        seed = 32'h9576;
    int                            cycles = 0;

    always #20 adc_clk = ~adc_clk;

    acq_readout_top u_dut (
        .adc_clk        (adc_clk),
        .reset_clk_adc  (reset_clk_adc),
        .adc_wr_en      (adc_wr_en),
        .adc_sample     (adc_sample),
        .rd_en          (rd_en),
        .trig_en        (trig_en),
        .bursts_per_wfm (bursts_per_wfm),
        .trig_req       (trig_req),
        .trig_addr      (trig_addr),
        .trig_ack       (trig_ack),
        .trig_wait      (trig_wait),
        .wr_active      (wr_active),
        .record         (record),
        .record_valid   (record_valid)
    );

    acq_readout_checker u_checker (
        .adc_clk        (adc_clk),
        .reset_clk_adc  (reset_clk_adc),
        .adc_wr_en      (adc_wr_en),
        .adc_sample     (adc_sample),
        .rd_en          (rd_en),
        .bursts_per_wfm (bursts_per_wfm),
        .trig_req       (trig_req),
        .trig_addr      (trig_addr),
        .trig_ack       (trig_ack),
        .trig_wait      (trig_wait),
        .wr_active      (wr_active),
        .record         (record),
        .record_valid   (record_valid),
        .test_id        (test_id),
        .test_wfms      (test_wfms),
        .test_done      (test_done),
        .all_done       (all_done),
        .error_count    (error_count)
    );

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    // four-phase entry with the address held until ack is seen
    task automatic send_trigger(input logic [`CBUF_ADDR_W-1:0] addr);
        trig_addr = addr;
        trig_req  = 1'b1;
        while (!trig_ack) @(negedge adc_clk);
        trig_req = 1'b0;
        while (trig_ack) @(negedge adc_clk);
    endtask

    // one-cycle strobe telling the checker a test is over
    task automatic finish_test(input int id, input int wfms);
        test_id   = id;
        test_wfms = wfms;
        test_done = 1'b1;
        @(negedge adc_clk);
        test_done = 1'b0;
    endtask

    task automatic run_fill(input int id, input logic [`BURST_CNT_W-1:0] bursts,
                            input int n, input logic near_end);
        logic [31:0] r;
        bursts_per_wfm = bursts;
        trig_en        = 1'b1;
        rd_en          = 1'b1;
        repeat (2) @(negedge adc_clk);
        for (int i = 0; i < n; i++) begin
            r = rnd();
            // second trigger sits in the last burst so its reads wrap
            if (near_end && i == 1) begin
                send_trigger(10'd1020 + {8'd0, r[1:0]});
            end else begin
                send_trigger(r[`CBUF_ADDR_W-1:0]);
            end
        end
        repeat (3) @(negedge adc_clk);
        trig_en = 1'b0;
        while (!(record_valid && record.record_kind == acq_readout_pkg::REC_FILL_HDR)) begin
            @(negedge adc_clk);
        end
        // releasing the fill sends the sequencer back to idle
        rd_en = 1'b0;
        while (wr_active) @(negedge adc_clk);
        repeat (4) @(negedge adc_clk);
        finish_test(id, n);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        reset_clk_adc  = 1'b1;
        adc_wr_en      = 1'b0;
        adc_sample     = '0;
        rd_en          = 1'b0;
        trig_en        = 1'b0;
        bursts_per_wfm = '0;
        trig_req       = 1'b0;
        trig_addr      = '0;
        test_id        = 0;
        test_wfms      = -1;
        test_done      = 1'b0;
        all_done       = 1'b0;
        repeat (3) @(negedge adc_clk);
        reset_clk_adc = 1'b0;
        @(negedge adc_clk);
        finish_test(1, -1);
        // random sample pairs over the whole buffer before writes stop
        adc_wr_en = 1'b1;
        repeat (1 << `CBUF_ADDR_W) begin
            r = rnd();
            adc_sample.pad      = '0;
            adc_sample.sample_b = r[23:12];
            adc_sample.sample_a = r[11:0];
            @(negedge adc_clk);
        end
        adc_wr_en = 1'b0;
        r = rnd();
        run_fill(2, 8'd1 + {5'd0, r[2:0]}, 1, 1'b0);
        r = rnd();
        run_fill(3, 8'd2 + {6'd0, r[1:0]}, 4, 1'b1);
        run_fill(4, 8'd3, 0, 1'b0);
        // long waveforms so the fifo fills behind them
        r = rnd();
        run_fill(5, 8'd4 + {6'd0, r[1:0]}, 6, 1'b0);
        all_done = 1'b1;
        @(negedge adc_clk);
        all_done = 1'b0;
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    always @(posedge adc_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

endmodule
